/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= kl10EbusTb
FILELIST  ?= kl10Ebus.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* aprFlags.sv */
`timescale 1ns/1ps

module aprFlags (
  input  logic                    clk,
  input  logic                    arstN,
  input  kl10EbusPkg::tEbusCmd    ebusCmd,
  input  logic [4:0]              errIn,
  output kl10EbusPkg::tEbusDriver aprDrv,
  output logic                    anyErr,
  output kl10EbusPkg::tPiReq      aprPiReq
);

  logic [4:0]           flags;
  logic [4:0]           enMask;
  kl10EbusPkg::tPiLevel level;
  kl10EbusPkg::tWord    breakReg;
  kl10EbusPkg::tWord    coniWord;
  logic                 selected;
  logic                 isCono;
  logic                 isConi;
  logic                 isDatao;
  logic                 isDatai;

  assign selected = ebusCmd.valid && (ebusCmd.dev == kl10EbusPkg::ApDev);
  assign isCono   = selected && (ebusCmd.func == kl10EbusPkg::CONO);
  assign isConi   = selected && (ebusCmd.func == kl10EbusPkg::CONI);
  assign isDatao  = selected && (ebusCmd.func == kl10EbusPkg::DATAO);
  assign isDatai  = selected && (ebusCmd.func == kl10EbusPkg::DATAI);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags  <= '0;
      enMask <= '0;
      level  <= '0;
    end else begin
      // A new error in the same cycle as its clear stays set
      flags <= (flags & ~(isCono ? ebusCmd.data[31:35] : 5'b0)) | errIn;
      if (isCono && ebusCmd.data[30]) begin
        enMask <= ebusCmd.data[25:29];
      end
      if (isCono && ebusCmd.data[21]) begin
        level <= ebusCmd.data[22:24];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (isDatao) begin
      breakReg <= ebusCmd.data;
    end
  end

  always_comb begin
    coniWord        = '0;
    coniWord[31:35] = flags;
    coniWord[25:29] = enMask;
    coniWord[22:24] = level;
  end

  assign aprDrv.driving = isConi || isDatai;
  assign aprDrv.data    = isConi ? coniWord : (isDatai ? breakReg : '0);

  assign anyErr         = |(flags & enMask);
  assign aprPiReq.req   = anyErr && (level != '0);
  assign aprPiReq.level = level;

endmodule

/* ebusMaster.sv */
`timescale 1ns/1ps

module ebusMaster (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 wbCyc,
  input  logic                 wbStb,
  input  logic                 wbWe,
  input  logic [8:0]           wbAdr,
  input  kl10EbusPkg::tWord    wbDatW,
  output kl10EbusPkg::tWord    wbDatR,
  output logic                 wbAck,
  input  kl10EbusPkg::tWord    ebusData,
  output kl10EbusPkg::tEbusCmd ebusCmd
);

  typedef enum logic {
    Idle,
    Busy
  } tState;

  tState                state;
  logic                 accept;
  logic                 isWriteFunc;
  kl10EbusPkg::tFunc    reqFunc;
  logic                 cmdValid;
  kl10EbusPkg::tDevCode cmdDev;
  kl10EbusPkg::tFunc    cmdFunc;
  kl10EbusPkg::tWord    cmdData;

  assign reqFunc     = kl10EbusPkg::tFunc'(wbAdr[1:0]);
  assign isWriteFunc = (reqFunc == kl10EbusPkg::CONO) || (reqFunc == kl10EbusPkg::DATAO);

  // A strobe is taken only when idle and not in the ack cycle
  assign accept = wbCyc && wbStb && (state == Idle) && !wbAck;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state    <= Idle;
      cmdValid <= 1'b0;
      wbAck    <= 1'b0;
    end else begin
      wbAck <= 1'b0;
      if (state == Idle) begin
        if (accept) begin
          state    <= Busy;
          // Reading a write function launches nothing on the bus
          cmdValid <= !(isWriteFunc && !wbWe);
        end
      end else begin
        state    <= Idle;
        cmdValid <= 1'b0;
        wbAck    <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmdDev  <= wbAdr[8:2];
      cmdFunc <= reqFunc;
      cmdData <= wbDatW;
    end
    // The merged bus word is sampled at the end of the command cycle
    if (state == Busy) begin
      wbDatR <= ebusData;
    end
  end

  assign ebusCmd = '{valid: cmdValid, dev: cmdDev, func: cmdFunc, data: cmdData};

endmodule

/* ebusMux.sv */
`timescale 1ns/1ps

module ebusMux #(
  parameter int NumDrivers = 3
) (
  input  logic                    clk,
  input  logic                    arstN,
  input  kl10EbusPkg::tEbusDriver drivers [NumDrivers],
  output kl10EbusPkg::tWord       ebusData,
  output logic                    busContention
);

  localparam int CntWidth = $clog2(NumDrivers + 1);

  logic [CntWidth-1:0] activeCount;

  // Walk from the last driver down so the lowest index wins
  always_comb begin
    ebusData    = '0;
    activeCount = '0;
    for (int i = NumDrivers - 1; i >= 0; i--) begin
      if (drivers[i].driving) begin
        ebusData    = drivers[i].data;
        activeCount = activeCount + CntWidth'(1);
      end
    end
  end

  // Sticky until reset
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busContention <= 1'b0;
    end else if (activeCount > CntWidth'(1)) begin
      busContention <= 1'b1;
    end
  end

endmodule

/* kl10Ebus.f */
kl10EbusPkg.sv
ebusMaster.sv
ebusMux.sv
aprFlags.sv
piLevels.sv
mtrTimer.sv
kl10Ebus.sv
kl10EbusAsserts.sv
kl10EbusTb.sv

/* kl10Ebus.sv */
`timescale 1ns/1ps

module kl10Ebus #(
  parameter int NumDrivers = 3,
  parameter int CountWidth = 18
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic [4:0]           errIn,
  input  logic                 wbCyc,
  input  logic                 wbStb,
  input  logic                 wbWe,
  input  logic [8:0]           wbAdr,
  input  kl10EbusPkg::tWord    wbDatW,
  output kl10EbusPkg::tWord    wbDatR,
  output logic                 wbAck,
  output logic                 anyErr,
  output kl10EbusPkg::tPiLevel piLevel,
  output logic                 busContention
);

  kl10EbusPkg::tEbusCmd    ebusCmd;
  kl10EbusPkg::tWord       ebusData;
  kl10EbusPkg::tEbusDriver aprDrv;
  kl10EbusPkg::tEbusDriver piDrv;
  kl10EbusPkg::tEbusDriver mtrDrv;
  kl10EbusPkg::tEbusDriver drivers [NumDrivers];
  kl10EbusPkg::tPiReq      aprPiReq;
  kl10EbusPkg::tPiReq      mtrPiReq;

  // Array order sets the bus priority, APR first
  assign drivers[0] = aprDrv;
  assign drivers[1] = piDrv;
  assign drivers[2] = mtrDrv;

  ebusMaster ebusMaster_i (
    .clk, .arstN, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck,
    .ebusData, .ebusCmd
  );

  ebusMux #(.NumDrivers(NumDrivers)) ebusMux_i (
    .clk, .arstN, .drivers, .ebusData, .busContention
  );

  aprFlags aprFlags_i (.clk, .arstN, .ebusCmd, .errIn, .aprDrv, .anyErr, .aprPiReq);

  piLevels piLevels_i (.clk, .arstN, .ebusCmd, .aprPiReq, .mtrPiReq, .piDrv, .piLevel);

  mtrTimer #(.CountWidth(CountWidth)) mtrTimer_i (
    .clk, .arstN, .ebusCmd, .mtrDrv, .mtrPiReq
  );

endmodule

/* kl10EbusAsserts.sv */
`timescale 1ns/1ps

module kl10EbusAsserts (
  input logic                    clk,
  input logic                    arstN,
  input logic                    wbCyc,
  input logic                    wbStb,
  input logic                    wbAck,
  input logic [8:0]              wbAdr,
  input kl10EbusPkg::tEbusDriver aprDrv,
  input kl10EbusPkg::tEbusDriver piDrv,
  input kl10EbusPkg::tEbusDriver mtrDrv
);

  function automatic logic isReadTo(input logic [8:0] adr,
                                    input kl10EbusPkg::tDevCode dev);
    kl10EbusPkg::tFunc func;
    func = kl10EbusPkg::tFunc'(adr[1:0]);
    return (adr[8:2] == dev) &&
           ((func == kl10EbusPkg::CONI) || (func == kl10EbusPkg::DATAI));
  endfunction

  ackOnePulse: assert property (@(posedge clk) disable iff (!arstN) wbAck |=> !wbAck)
    else $error("wbAck stayed high for more than one cycle");

  // The strobe was taken two edges before the ack, outside an ack cycle
  ackAfterStrobe: assert property (@(posedge clk) disable iff (!arstN)
    wbAck |-> $past(wbCyc && wbStb && !wbAck, 2))
    else $error("wbAck without a strobe accepted two cycles earlier");

  // A device may drive only in the command cycle of a host read to its own code
  aprDrive: assert property (@(posedge clk) disable iff (!arstN)
    aprDrv.driving |-> $past(wbCyc && wbStb && isReadTo(wbAdr, kl10EbusPkg::ApDev)))
    else $error("APR drives the EBUS without a read command");

  piDrive: assert property (@(posedge clk) disable iff (!arstN)
    piDrv.driving |-> $past(wbCyc && wbStb && isReadTo(wbAdr, kl10EbusPkg::PiDev)))
    else $error("PI drives the EBUS without a read command");

  mtrDrive: assert property (@(posedge clk) disable iff (!arstN)
    mtrDrv.driving |-> $past(wbCyc && wbStb && isReadTo(wbAdr, kl10EbusPkg::MtrDev)))
    else $error("MTR drives the EBUS without a read command");

endmodule

bind kl10Ebus kl10EbusAsserts kl10EbusAsserts_i (
  .clk(clk), .arstN(arstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbAck(wbAck),
  .wbAdr(wbAdr), .aprDrv(aprDrv), .piDrv(piDrv), .mtrDrv(mtrDrv)
);

/* kl10EbusPatterns.txt */
// Columns: op addr data mask, all hex. addr is device code * 4 + function
// op 1 write, 2 read and compare with data, 3 poll until (read & mask) == data
// op 4 pulse errIn = addr, 5 check piLevel = addr, anyErr = data, busContention = mask
// op 0 ends the run
2 001 000000000 000000000
2 005 000000000 000000000
2 009 000000000 000000000
2 015 000000000 000000000
5 000 000000000 000000000
1 002 123456789 000000000
2 003 123456789 000000000
2 005 000000000 000000000
4 005 000000000 000000000
5 000 000000000 000000000
2 001 000000005 000000000
1 000 000000120 000000000
5 000 000000001 000000000
2 001 000000105 000000000
1 000 000000004 000000000
2 001 000000101 000000000
5 000 000000000 000000000
1 004 000000A16 000000000
1 004 000000094 000000000
5 003 000000000 000000000
2 005 000001694 000000000
1 004 000000110 000000000
5 005 000000000 000000000
1 004 000000400 000000000
5 000 000000000 000000000
1 004 000001A08 000000000
1 00A 000000005 000000000
1 008 00000000C 000000000
3 009 000000040 000000040
5 004 000000000 000000000
2 009 00000004C 000000000
1 008 000000014 000000000
1 008 000000024 000000000
5 000 000000000 000000000
0 000 000000000 000000000

/* kl10EbusPkg.sv */
package kl10EbusPkg;

  // One EBUS word, bit 0 is the most significant as on the real machine
  typedef logic [0:35] tWord;

  // EBUS I/O functions, encoded as the low two bits of the host address
  typedef enum logic [1:0] {
    CONO  = 2'd0,
    CONI  = 2'd1,
    DATAO = 2'd2,
    DATAI = 2'd3
  } tFunc;

  typedef logic [6:0] tDevCode;

  localparam tDevCode ApDev  = 7'd0;
  localparam tDevCode PiDev  = 7'd1;
  localparam tDevCode MtrDev = 7'd2;

  // Command broadcast by the master to every device
  typedef struct packed {
    logic    valid;
    tDevCode dev;
    tFunc    func;
    tWord    data;
  } tEbusCmd;

  // Each device offers its read data through one of these
  typedef struct packed {
    logic driving;
    tWord data;
  } tEbusDriver;

  // Level 1 is the highest priority, 0 means no level
  typedef logic [2:0] tPiLevel;

  typedef struct packed {
    logic    req;
    tPiLevel level;
  } tPiReq;

endpackage

/* kl10EbusTb.sv */
`timescale 1ns/1ps

module kl10EbusTb;

  localparam int MaxOps    = 64;
  localparam int AckLimit  = 16;
  localparam int PollLimit = 100;

  logic                 clk;
  logic                 arstN;
  logic [4:0]           errIn;
  logic                 wbCyc;
  logic                 wbStb;
  logic                 wbWe;
  logic [8:0]           wbAdr;
  kl10EbusPkg::tWord    wbDatW;
  kl10EbusPkg::tWord    wbDatR;
  logic                 wbAck;
  logic                 anyErr;
  kl10EbusPkg::tPiLevel piLevel;
  logic                 busContention;

  // Four words per operation: opcode, address or value, data, mask
  logic [35:0] patMem [4*MaxOps];

  kl10Ebus #(.NumDrivers(3), .CountWidth(18)) kl10Ebus_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic failNow();
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic matchWord(input string name, input kl10EbusPkg::tWord got,
                           input kl10EbusPkg::tWord exp);
    if (got !== exp) begin
      $display("[FAIL] %0d ns %s got %h expected %h", $time, name, got, exp);
      failNow();
    end
  endtask

  task automatic checkLevel(input string name, input kl10EbusPkg::tPiLevel got,
                            input kl10EbusPkg::tPiLevel exp);
    if (got !== exp) begin
      $display("[FAIL] %0d ns %s got %0d expected %0d", $time, name, got, exp);
      failNow();
    end
  endtask

  task automatic verifyBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0d ns %s got %b expected %b", $time, name, got, exp);
      failNow();
    end
  endtask

  // Starts and ends on a falling edge, the strobe is held until ack
  task automatic runTransfer(input logic we, input logic [8:0] adr,
                             input kl10EbusPkg::tWord data, output kl10EbusPkg::tWord rd);
    int waited;
    waited = 0;
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = we;
    wbAdr  = adr;
    wbDatW = data;
    do begin
      @(negedge clk);
      waited++;
      if (waited > AckLimit) begin
        $display("No Wishbone ack within %0d cycles for address %h", AckLimit, adr);
        failNow();
      end
    end while (!wbAck);
    rd    = wbDatR;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  task automatic pollWord(input logic [8:0] adr, input kl10EbusPkg::tWord exp,
                          input kl10EbusPkg::tWord mask);
    kl10EbusPkg::tWord rd;
    int tries;
    tries = 0;
    do begin
      if (tries == PollLimit) begin
        $display("Address %h did not reach the expected value in %0d reads", adr, PollLimit);
        failNow();
      end
      runTransfer(1'b0, adr, '0, rd);
      tries++;
    end while ((rd & mask) !== exp);
  endtask

  task automatic pulseErrors(input logic [4:0] value);
    errIn = value;
    @(negedge clk);
    errIn = '0;
  endtask

  initial begin
    kl10EbusPkg::tWord rd;
    logic [3:0]        op;
    logic [35:0]       arg;
    logic [35:0]       data;
    logic [35:0]       mask;
    int                n;
    logic              ended;

    arstN  = 1'b0;
    errIn  = '0;
    wbCyc  = 1'b0;
    wbStb  = 1'b0;
    wbWe   = 1'b0;
    wbAdr  = '0;
    wbDatW = '0;
    n      = 0;
    ended  = 1'b0;
    for (int i = 0; i < 4*MaxOps; i++) begin
      patMem[i] = '0;
    end
    $readmemh("kl10EbusPatterns.txt", patMem);
    repeat (3) @(negedge clk);
    arstN = 1'b1;
    @(negedge clk);

    while (!ended && n < MaxOps) begin
      op   = patMem[4*n][3:0];
      arg  = patMem[4*n+1];
      data = patMem[4*n+2];
      mask = patMem[4*n+3];
      case (op)
        4'h0: ended = 1'b1;
        4'h1: runTransfer(1'b1, arg[8:0], data, rd);
        4'h2: begin
          runTransfer(1'b0, arg[8:0], '0, rd);
          matchWord("wbDatR", rd, data);
        end
        4'h3: pollWord(arg[8:0], data, mask);
        4'h4: pulseErrors(arg[4:0]);
        4'h5: begin
          checkLevel("piLevel", piLevel, arg[2:0]);
          verifyBit("anyErr", anyErr, data[0]);
          verifyBit("busContention", busContention, mask[0]);
        end
        default: begin
          $display("Unknown operation %h in pattern entry %0d", op, n);
          failNow();
        end
      endcase
      n++;
    end

    if (ended) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Pattern file ended without its end marker");
      failNow();
    end
  end

endmodule

/* mtrTimer.sv */
`timescale 1ns/1ps

module mtrTimer #(
  parameter int CountWidth = 18
) (
  input  logic                    clk,
  input  logic                    arstN,
  input  kl10EbusPkg::tEbusCmd    ebusCmd,
  output kl10EbusPkg::tEbusDriver mtrDrv,
  output kl10EbusPkg::tPiReq      mtrPiReq
);

  logic [CountWidth-1:0] interval;
  logic [CountWidth-1:0] count;
  logic                  run;
  logic                  done;
  kl10EbusPkg::tPiLevel  level;
  kl10EbusPkg::tWord     readWord;
  logic                  selected;
  logic                  isCono;
  logic                  isConi;
  logic                  isDatao;
  logic                  isDatai;

  assign selected = ebusCmd.valid && (ebusCmd.dev == kl10EbusPkg::MtrDev);
  assign isCono   = selected && (ebusCmd.func == kl10EbusPkg::CONO);
  assign isConi   = selected && (ebusCmd.func == kl10EbusPkg::CONI);
  assign isDatao  = selected && (ebusCmd.func == kl10EbusPkg::DATAO);
  assign isDatai  = selected && (ebusCmd.func == kl10EbusPkg::DATAI);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      interval <= '0;
      count    <= '0;
      run      <= 1'b0;
      done     <= 1'b0;
      level    <= '0;
    end else begin
      if (isCono) begin
        if (ebusCmd.data[31]) begin
          run <= 1'b0;
        end else if (ebusCmd.data[32]) begin
          run <= 1'b1;
        end
        if (ebusCmd.data[30]) begin
          done <= 1'b0;
        end
        level <= ebusCmd.data[33:35];
      end
      // A load restarts the count, otherwise the counter runs down and reloads
      if (isDatao) begin
        interval <= ebusCmd.data[36-CountWidth +: CountWidth];
        count    <= ebusCmd.data[36-CountWidth +: CountWidth];
      end else if (run) begin
        if (count == '0) begin
          count <= interval;
          done  <= 1'b1;
        end else begin
          count <= count - CountWidth'(1);
        end
      end
    end
  end

  always_comb begin
    readWord = '0;
    if (isConi) begin
      readWord[29]    = done;
      readWord[32]    = run;
      readWord[33:35] = level;
    end else if (isDatai) begin
      readWord[36-CountWidth +: CountWidth] = count;
    end
  end

  assign mtrDrv.driving = isConi || isDatai;
  assign mtrDrv.data    = readWord;

  assign mtrPiReq.req   = done;
  assign mtrPiReq.level = level;

endmodule

/* piLevels.sv */
`timescale 1ns/1ps

module piLevels (
  input  logic                    clk,
  input  logic                    arstN,
  input  kl10EbusPkg::tEbusCmd    ebusCmd,
  input  kl10EbusPkg::tPiReq      aprPiReq,
  input  kl10EbusPkg::tPiReq      mtrPiReq,
  output kl10EbusPkg::tEbusDriver piDrv,
  output kl10EbusPkg::tPiLevel    piLevel
);

  // Index k of these vectors is priority level k
  logic [1:7]        levelEn;
  logic [1:7]        swReq;
  logic [1:7]        pending;
  logic [1:7]        levelSel;
  logic              sysEn;
  logic              isCono;
  logic              isConi;
  kl10EbusPkg::tWord coniWord;

  assign isCono   = ebusCmd.valid && (ebusCmd.dev == kl10EbusPkg::PiDev) &&
                    (ebusCmd.func == kl10EbusPkg::CONO);
  assign isConi   = ebusCmd.valid && (ebusCmd.dev == kl10EbusPkg::PiDev) &&
                    (ebusCmd.func == kl10EbusPkg::CONI);
  assign levelSel = ebusCmd.data[29:35];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      sysEn   <= 1'b0;
      levelEn <= '0;
      swReq   <= '0;
    end else if (isCono) begin
      // Clear wins when both set and clear bits are given
      if (ebusCmd.data[25]) begin
        sysEn <= 1'b0;
      end else if (ebusCmd.data[24]) begin
        sysEn <= 1'b1;
      end
      if (ebusCmd.data[27]) begin
        levelEn <= levelEn & ~levelSel;
      end else if (ebusCmd.data[26]) begin
        levelEn <= levelEn | levelSel;
      end
      swReq <= (ebusCmd.data[23] ? 7'b0 : swReq) | (ebusCmd.data[28] ? levelSel : 7'b0);
    end
  end

  always_comb begin
    for (int k = 1; k <= 7; k++) begin
      pending[k] = swReq[k] ||
                   (aprPiReq.req && (aprPiReq.level == kl10EbusPkg::tPiLevel'(k))) ||
                   (mtrPiReq.req && (mtrPiReq.level == kl10EbusPkg::tPiLevel'(k)));
    end
  end

  // Scan from level 7 upwards so the highest priority is left standing
  always_comb begin
    piLevel = '0;
    if (sysEn) begin
      for (int k = 7; k >= 1; k--) begin
        if (pending[k] && levelEn[k]) begin
          piLevel = kl10EbusPkg::tPiLevel'(k);
        end
      end
    end
  end

  always_comb begin
    coniWord        = '0;
    coniWord[29:35] = pending;
    coniWord[28]    = sysEn;
    coniWord[21:27] = levelEn;
  end

  assign piDrv.driving = isConi;
  assign piDrv.data    = isConi ? coniWord : '0;

endmodule
